/* dv/cfo_calc_input.txt */
// columns: C0 (im:re), C1 (im:re), expected CFO angle, all hex
10002000 00004000 12e40
20001000 00004000 2d1c0
1000e000 00004000 6d1c0
f000e000 00004000 92e40
f0002000 00004000 ed1c0
20001800 00004000 25c81
2000e800 00004000 5a37f
e0001800 00004000 da37f
20002000 00004000 20001
0000e000 00004000 80000
00002000 f0002000 12e40
20000000 18002000 25c81
00040008 00000010 12e40
fffffffe 00000004 92e40
00000001 00010001 dffff
00004000 40004000 dffff

/* cfo_calc.f */
+incdir+design
design/cfo_pkg.sv
design/complex_multiplier.sv
design/div.sv
design/atan_lut.sv
design/cfo_calc.sv
dv/cfo_calc_checker.sv
dv/tb_cfo_calc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cfo_calc
FILELIST  ?= cfo_calc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_cfo_calc.sv */
module tb_cfo_calc;
    import cfo_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int PI_INT         = 2 * PI_HALF;

    logic                     clk;
    logic                     reset_n;
    logic [C_DW-1:0]          c0;
    logic [C_DW-1:0]          c1;
    logic                     valid_in;
    logic signed [CFO_DW-1:0] angle;
    logic signed [DDS_DW-1:0] dds_inc;
    logic                     valid_out;

    int                       value_errors;
    int                       other_errors;
    int                       case_count;
    bit                       timed_out;
    logic signed [CFO_DW-1:0] held_angle;
    logic signed [DDS_DW-1:0] held_inc;

    cfo_calc #(
        .CFO_DW (CFO_DW),
        .DDS_DW (DDS_DW)
    ) u_cfo_calc (
        .clk_i         (clk),
        .reset_ni      (reset_n),
        .C0_i          (c0),
        .C1_i          (c1),
        .valid_i       (valid_in),
        .CFO_angle_o   (angle),
        .CFO_DDS_inc_o (dds_inc),
        .valid_o       (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_angle(input logic signed [CFO_DW-1:0] got,
                               input logic signed [CFO_DW-1:0] exp_val, input string tag);
        if (got !== exp_val) begin
            value_errors++;
            $display("FAILED CFO_angle_o (%s): got 0x%05h, expected 0x%05h", tag, got, exp_val);
        end
    endtask

    task automatic check_inc(input logic signed [DDS_DW-1:0] got,
                             input logic signed [DDS_DW-1:0] exp_val, input string tag);
        if (got !== exp_val) begin
            value_errors++;
            $display("FAILED CFO_DDS_inc_o (%s): got 0x%05h, expected 0x%05h", tag, got, exp_val);
        end
    endtask

    task automatic check_reset_outputs();
        if (valid_out !== 1'b0) begin
            other_errors++;
            $display("valid_o is not low during or right after reset");
        end
        check_angle(angle, '0, "reset");
        check_inc(dds_inc, '0, "reset");
    endtask

    // fold the angle back to the first quadrant using the signs of c0 * conj(c1)
    task automatic check_quadrant(input logic [C_DW-1:0] c0v, input logic [C_DW-1:0] c1v,
                                  input logic signed [CFO_DW-1:0] got, input string tag);
        cplx_u  a;
        cplx_u  b;
        longint p_re;
        longint p_im;
        int     ang;
        int     folded;
        bit     re_dominant;
        a.raw  = c0v;
        b.raw  = c1v;
        p_re   = longint'(a.part.re) * longint'(b.part.re)
               + longint'(a.part.im) * longint'(b.part.im);
        p_im   = longint'(a.part.im) * longint'(b.part.re)
               - longint'(a.part.re) * longint'(b.part.im);
        ang    = int'(got);
        if (p_re >= 0 && p_im >= 0) begin
            folded = ang;
        end else if (p_re < 0 && p_im >= 0) begin
            // -pi counts as the upper edge of the second quadrant
            folded = (PI_INT - ang) % (2 * PI_INT);
        end else if (p_re < 0) begin
            folded = ang + PI_INT;
        end else begin
            folded = -ang;
        end
        re_dominant = ((p_re < 0) ? -p_re : p_re) > ((p_im < 0) ? -p_im : p_im);
        if (folded < 0 || folded > PI_HALF) begin
            other_errors++;
            $display("angle 0x%05h (%s) lies outside the quadrant of the product", got, tag);
        end else if (re_dominant == (folded >= PI_QUARTER)) begin
            other_errors++;
            $display("angle 0x%05h (%s) lies in the wrong octant of its quadrant", got, tag);
        end
    endtask

    task automatic wait_for_result(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
            if (valid_out) begin
                seen = 1'b1;
            end else if (angle !== held_angle || dds_inc !== held_inc) begin
                other_errors++;
                $display("outputs changed while valid_o was low");
            end
        end
    endtask

    task automatic run_case(input logic [C_DW-1:0] c0v, input logic [C_DW-1:0] c1v,
                            input logic signed [CFO_DW-1:0] exp_angle);
        bit                       seen;
        string                    tag;
        logic signed [CFO_DW-1:0] shifted;
        logic signed [DDS_DW-1:0] exp_inc;
        case_count++;
        tag = $sformatf("case %0d", case_count);
        @(posedge clk);
        #1;
        c0       = c0v;
        c1       = c1v;
        valid_in = 1'b1;
        @(posedge clk);
        #1;
        valid_in = 1'b0;
        wait_for_result(seen);
        if (!seen) begin
            timed_out = 1'b1;
            other_errors++;
            $display("no valid_o within %0d cycles in %s", TIMEOUT_CYCLES, tag);
        end else begin
            check_angle(angle, exp_angle, tag);
            // increment is the observed angle divided by 64
            shifted = angle >>> 6;
            exp_inc = DDS_DW'(shifted);
            check_inc(dds_inc, exp_inc, tag);
            check_quadrant(c0v, c1v, angle, tag);
            held_angle = angle;
            held_inc   = dds_inc;
            @(posedge clk);
            #1;
            if (valid_out) begin
                other_errors++;
                $display("valid_o stayed high for more than one cycle in %s", tag);
            end
        end
    endtask

    initial begin
        int                fd;
        int                n;
        string             line;
        logic [C_DW-1:0]   c0_v;
        logic [C_DW-1:0]   c1_v;
        logic [CFO_DW-1:0] exp_v;
        value_errors = 0;
        other_errors = 0;
        case_count   = 0;
        timed_out    = 1'b0;
        held_angle   = '0;
        held_inc     = '0;
        reset_n      = 1'b0;
        valid_in     = 1'b0;
        c0           = '0;
        c1           = '0;
        repeat (10) begin
            @(posedge clk);
            #1;
            check_reset_outputs();
        end
        reset_n = 1'b1;
        @(posedge clk);
        #1;
        check_reset_outputs();

        fd = $fopen("dv/cfo_calc_input.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the vector file dv/cfo_calc_input.txt");
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.substr(0, 1) == "//") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h", c0_v, c1_v, exp_v);
                if (n != 3) begin
                    other_errors++;
                    $display("vector line could not be read: %s", line);
                end else begin
                    run_case(c0_v, c1_v, exp_v);
                end
            end
            $fclose(fd);
        end
        if (case_count == 0) begin
            other_errors++;
            $display("no vectors were run");
        end

        $display("%0d cases, %0d wrong values, %0d other failures",
                 case_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* dv/cfo_calc_checker.sv */
module cfo_calc_checker #(
    parameter int CFO_DW = cfo_pkg::CFO_DW,
    parameter int DDS_DW = cfo_pkg::DDS_DW
) (
    input logic                     clk_i,
    input logic                     reset_ni,
    input logic                     valid_i,
    input logic                     out_valid_i,
    input logic signed [CFO_DW-1:0] angle_i,
    input logic signed [DDS_DW-1:0] inc_i,
    input logic [2:0]               state_i
);

    // idle state code of the cfo_calc FSM
    localparam logic [2:0] IDLE = 3'd0;

    valid_single_pulse: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_valid_i |=> !out_valid_i)
        else $error("valid_o stayed high for two cycles running");

    outputs_cleared: assert property (@(posedge clk_i)
        !reset_ni |=> (!out_valid_i && angle_i == '0 && inc_i == '0))
        else $error("valid_o or the outputs are not zero after a reset cycle");

    input_only_when_idle: assert property (@(posedge clk_i) disable iff (!reset_ni)
        valid_i |-> state_i == IDLE)
        else $error("valid_i raised while an estimate is in progress");

endmodule

bind cfo_calc cfo_calc_checker #(
    .CFO_DW (CFO_DW),
    .DDS_DW (DDS_DW)
) u_cfo_calc_checker (
    .clk_i       (clk_i),
    .reset_ni    (reset_ni),
    .valid_i     (valid_i),
    .out_valid_i (valid_o),
    .angle_i     (CFO_angle_o),
    .inc_i       (CFO_DDS_inc_o),
    .state_i     (state_q)
);

/* design/cfo_calc.sv */
module cfo_calc #(
    parameter int CFO_DW = cfo_pkg::CFO_DW,
    parameter int DDS_DW = cfo_pkg::DDS_DW
) (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic [cfo_pkg::C_DW-1:0] C0_i,
    input  logic [cfo_pkg::C_DW-1:0] C1_i,
    input  logic                     valid_i,
    output logic signed [CFO_DW-1:0] CFO_angle_o,
    output logic signed [DDS_DW-1:0] CFO_DDS_inc_o,
    output logic                     valid_o
);
    import cfo_pkg::*;

    localparam int HW     = C_DW / 2;
    localparam int SW     = $clog2(HW);
    localparam int LUT_DW = CFO_DW - 3;
    localparam int DIV_DW = 2 * ATAN_IN_DW;

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_SCALE    = 3'd1;
    localparam logic [2:0] S_MULTIPLY = 3'd2;
    localparam logic [2:0] S_DIVIDE   = 3'd3;
    localparam logic [2:0] S_LOOKUP   = 3'd4;
    localparam logic [2:0] S_UNFOLD   = 3'd5;
    localparam logic [2:0] S_OUTPUT   = 3'd6;

    logic [2:0]              state_q;
    logic [SW-1:0]           msb_q;
    cplx_u                   c0_q;
    cplx_u                   c1_q;
    logic                    mult_valid;
    logic                    mult_valid_out;
    prod_u                   mult_prod;
    prod_u                   prod_q;
    logic                    div_valid;
    logic                    div_valid_out;
    logic [DIV_DW-1:0]       num_wide_q;
    logic [DIV_DW-1:0]       den_wide_q;
    logic [ATAN_IN_DW-1:0]   div_result;
    logic                    swap_q;
    logic [ATAN_IN_DW-1:0]   atan_arg_q;
    logic [LUT_DW-1:0]       atan_angle;
    logic signed [CFO_DW-1:0] angle_q;

    logic [ATAN_IN_DW-1:0]   abs_im;
    logic [ATAN_IN_DW-1:0]   abs_re;
    logic [SW-1:0]           shamt;
    logic                    all_unused;
    logic signed [CFO_DW-1:0] oct_ext;
    logic signed [CFO_DW-1:0] quad1;
    logic signed [CFO_DW-1:0] full_angle;
    logic signed [CFO_DW-1:0] angle_sh;

    // bit pos carries information if it differs from the sign bit
    function automatic logic bit_used(logic [HW-1:0] data, logic [SW-1:0] pos);
        return data[HW-1] ^ data[pos];
    endfunction

    assign abs_im = mult_prod.part.im[ATAN_IN_DW-1] ? -mult_prod.part.im : mult_prod.part.im;
    assign abs_re = mult_prod.part.re[ATAN_IN_DW-1] ? -mult_prod.part.re : mult_prod.part.re;

    assign all_unused = !bit_used(c0_q.part.im, msb_q) && !bit_used(c0_q.part.re, msb_q)
                     && !bit_used(c1_q.part.im, msb_q) && !bit_used(c1_q.part.re, msb_q);
    assign shamt = SW'(HW - 2) - msb_q;

    // first quadrant from the octant, then mirror by product signs
    assign oct_ext = CFO_DW'(atan_angle);
    assign quad1   = swap_q ? PI_HALF - oct_ext : oct_ext;
    always_comb begin
        case ({prod_q.part.im[ATAN_IN_DW-1], prod_q.part.re[ATAN_IN_DW-1]})
            2'b00:   full_angle = quad1;
            // pi - a, wraps to -pi for a zero
            2'b01:   full_angle = PI_HALF + PI_HALF - quad1;
            2'b11:   full_angle = quad1 - PI_HALF - PI_HALF;
            default: full_angle = -quad1;
        endcase
    end

    assign angle_sh = angle_q >>> 6;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q       <= S_IDLE;
            msb_q         <= SW'(HW - 2);
            mult_valid    <= 1'b0;
            div_valid     <= 1'b0;
            swap_q        <= 1'b0;
            valid_o       <= 1'b0;
            CFO_angle_o   <= '0;
            CFO_DDS_inc_o <= '0;
        end else begin
            valid_o    <= 1'b0;
            mult_valid <= 1'b0;
            div_valid  <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (valid_i) begin
                        c0_q.raw <= C0_i;
                        c1_q.raw <= C1_i;
                        msb_q    <= SW'(HW - 2);
                        state_q  <= S_SCALE;
                    end
                end
                S_SCALE: begin
                    if (all_unused && msb_q != '0) begin
                        msb_q <= msb_q - 1'b1;
                    end else begin
                        // one common shift keeps the ratio
                        c0_q.part.im <= c0_q.part.im <<< shamt;
                        c0_q.part.re <= c0_q.part.re <<< shamt;
                        c1_q.part.im <= c1_q.part.im <<< shamt;
                        c1_q.part.re <= c1_q.part.re <<< shamt;
                        mult_valid   <= 1'b1;
                        state_q      <= S_MULTIPLY;
                    end
                end
                S_MULTIPLY: begin
                    if (mult_valid_out) begin
                        prod_q.raw <= mult_prod.raw;
                        swap_q     <= abs_re <= abs_im;
                        if (abs_re > abs_im) begin
                            num_wide_q <= {abs_im, {ATAN_IN_DW{1'b0}}};
                            den_wide_q <= DIV_DW'(abs_re);
                        end else begin
                            num_wide_q <= {abs_re, {ATAN_IN_DW{1'b0}}};
                            den_wide_q <= DIV_DW'(abs_im);
                        end
                        div_valid <= 1'b1;
                        state_q   <= S_DIVIDE;
                    end
                end
                S_DIVIDE: begin
                    if (div_valid_out) begin
                        atan_arg_q <= div_result;
                        state_q    <= S_LOOKUP;
                    end
                end
                // table output registers on this edge
                S_LOOKUP: state_q <= S_UNFOLD;
                S_UNFOLD: begin
                    angle_q <= full_angle;
                    state_q <= S_OUTPUT;
                end
                S_OUTPUT: begin
                    CFO_angle_o   <= angle_q;
                    // divide by 64, then fit the DDS width
                    CFO_DDS_inc_o <= DDS_DW'(angle_sh);
                    valid_o       <= 1'b1;
                    state_q       <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // b is conjugated inside the multiplier
    complex_multiplier #(
        .INPUT_WIDTH  (HW),
        .OUTPUT_WIDTH (ATAN_IN_DW)
    ) u_complex_multiplier (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .a_i      (c0_q),
        .b_i      (c1_q),
        .valid_i  (mult_valid),
        .prod_o   (mult_prod),
        .valid_o  (mult_valid_out)
    );

    div #(
        .INPUT_WIDTH  (DIV_DW),
        .RESULT_WIDTH (ATAN_IN_DW)
    ) u_div (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .numerator_i   (num_wide_q),
        .denominator_i (den_wide_q),
        .valid_i       (div_valid),
        .result_o      (div_result),
        .valid_o       (div_valid_out)
    );

    atan_lut #(
        .INPUT_WIDTH  (ATAN_IN_DW),
        .OUTPUT_WIDTH (LUT_DW)
    ) u_atan_lut (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .arg_i    (atan_arg_q),
        .angle_o  (atan_angle)
    );

endmodule

/* design/atan_lut.sv */
module atan_lut #(
    parameter int INPUT_WIDTH  = 16,
    parameter int OUTPUT_WIDTH = 17
) (
    input  logic                    clk_i,
    input  logic                    reset_ni,
    input  logic [INPUT_WIDTH-1:0]  arg_i,
    output logic [OUTPUT_WIDTH-1:0] angle_o
);
    import cfo_pkg::*;

`include "atan_table.svh"

    logic [ATAN_LUT_AW-1:0] idx;

    // ratio is a fraction, upper bits pick the entry
    assign idx = arg_i[INPUT_WIDTH-1 -: ATAN_LUT_AW];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            angle_o <= '0;
        end else if (&arg_i) begin
            // saturated quotient, ratio of one
            angle_o <= ATAN_MAX;
        end else begin
            angle_o <= ATAN_TABLE[idx*OUTPUT_WIDTH +: OUTPUT_WIDTH];
        end
    end

endmodule

/* design/div.sv */
module div #(
    parameter int INPUT_WIDTH  = 32,
    parameter int RESULT_WIDTH = 16
) (
    input  logic                    clk_i,
    input  logic                    reset_ni,
    input  logic [INPUT_WIDTH-1:0]  numerator_i,
    input  logic [INPUT_WIDTH-1:0]  denominator_i,
    input  logic                    valid_i,
    output logic [RESULT_WIDTH-1:0] result_o,
    output logic                    valid_o
);

    localparam int CW = $clog2(RESULT_WIDTH);

    logic                    busy_q;
    logic [CW-1:0]           cnt_q;
    logic                    ovf_q;
    logic [INPUT_WIDTH-1:0]  rem_q;
    logic [INPUT_WIDTH-1:0]  den_q;
    // low numerator bits shift out at the top, quotient bits shift in
    logic [RESULT_WIDTH-1:0] quo_q;

    logic [INPUT_WIDTH:0]    rem_sh;
    logic                    q_bit;
    logic [RESULT_WIDTH-1:0] quo_next;

    assign rem_sh   = {rem_q, quo_q[RESULT_WIDTH-1]};
    assign q_bit    = rem_sh >= {1'b0, den_q};
    assign quo_next = {quo_q[RESULT_WIDTH-2:0], q_bit};

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q   <= 1'b0;
            cnt_q    <= '0;
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= 1'b0;
            if (!busy_q && valid_i) begin
                busy_q <= 1'b1;
                cnt_q  <= CW'(RESULT_WIDTH - 1);
                rem_q  <= INPUT_WIDTH'(numerator_i[INPUT_WIDTH-1:RESULT_WIDTH]);
                quo_q  <= numerator_i[RESULT_WIDTH-1:0];
                den_q  <= denominator_i;
                // quotient cannot fit, also catches a zero denominator
                ovf_q  <= numerator_i[INPUT_WIDTH-1:RESULT_WIDTH] >= denominator_i;
            end else if (busy_q) begin
                rem_q <= q_bit ? INPUT_WIDTH'(rem_sh - {1'b0, den_q})
                               : INPUT_WIDTH'(rem_sh);
                quo_q <= quo_next;
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == '0) begin
                    busy_q   <= 1'b0;
                    valid_o  <= 1'b1;
                    result_o <= ovf_q ? '1 : quo_next;
                end
            end
        end
    end

endmodule

/* design/complex_multiplier.sv */
module complex_multiplier #(
    parameter int INPUT_WIDTH  = 16,
    parameter int OUTPUT_WIDTH = 16
) (
    input  logic           clk_i,
    input  logic           reset_ni,
    input  cfo_pkg::cplx_u a_i,
    input  cfo_pkg::cplx_u b_i,
    input  logic           valid_i,
    output cfo_pkg::prod_u prod_o,
    output logic           valid_o
);
    import cfo_pkg::*;

    localparam int PW = 2 * INPUT_WIDTH;

    // stage 1 partial products
    logic signed [PW-1:0] re_re_q;
    logic signed [PW-1:0] im_im_q;
    logic signed [PW-1:0] im_re_q;
    logic signed [PW-1:0] re_im_q;
    logic                 valid_q;

    // a * conj(b) = (ar*br + ai*bi) + j(ai*br - ar*bi)
    logic signed [PW:0] sum_re;
    logic signed [PW:0] sum_im;

    assign sum_re = (PW+1)'(re_re_q) + (PW+1)'(im_im_q);
    assign sum_im = (PW+1)'(im_re_q) - (PW+1)'(re_im_q);

    always_ff @(posedge clk_i) begin
        re_re_q <= a_i.part.re * b_i.part.re;
        im_im_q <= a_i.part.im * b_i.part.im;
        im_re_q <= a_i.part.im * b_i.part.re;
        re_im_q <= a_i.part.re * b_i.part.im;
        // keep the top bits of each sum
        prod_o.part.re <= sum_re[PW -: OUTPUT_WIDTH];
        prod_o.part.im <= sum_im[PW -: OUTPUT_WIDTH];
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_q <= valid_i;
            valid_o <= valid_q;
        end
    end

endmodule

/* design/cfo_pkg.sv */
package cfo_pkg;

    // complex input word, imaginary part in the upper half
    localparam int C_DW = 32;
    // angle output, 2**(CFO_DW-1) stands for pi
    localparam int CFO_DW = 20;
    localparam int DDS_DW = 20;
    // product parts and divider quotient
    localparam int ATAN_IN_DW = 16;
    // table address, taken from the upper quotient bits
    localparam int ATAN_LUT_AW = 8;

    typedef union packed {
        logic [C_DW-1:0] raw;
        struct packed {
            logic signed [C_DW/2-1:0] im;
            logic signed [C_DW/2-1:0] re;
        } part;
    } cplx_u;

    typedef union packed {
        logic [2*ATAN_IN_DW-1:0] raw;
        struct packed {
            logic signed [ATAN_IN_DW-1:0] im;
            logic signed [ATAN_IN_DW-1:0] re;
        } part;
    } prod_u;

    localparam logic signed [CFO_DW-1:0] PI_HALF    = 2 ** (CFO_DW - 2);
    localparam logic signed [CFO_DW-1:0] PI_QUARTER = 2 ** (CFO_DW - 3);

endpackage

/* design/atan_table.svh */
`ifndef ATAN_TABLE_SVH
`define ATAN_TABLE_SVH

// first-octant arctangent table
// entry k holds atan(k / 2**ATAN_LUT_AW), scaled so that pi/4 is 2**OUTPUT_WIDTH
// the table is built at elaboration, entries are packed into one flat vector

localparam int  ATAN_ENTRIES = 2 ** ATAN_LUT_AW;
localparam real ATAN_PI      = 3.14159265358979;

function automatic logic [ATAN_ENTRIES*OUTPUT_WIDTH-1:0] build_atan_table();
    logic [ATAN_ENTRIES*OUTPUT_WIDTH-1:0] table_v;
    real ratio;
    real scaled;
    int  entry;
    table_v = '0;
    for (int k = 0; k < ATAN_ENTRIES; k++) begin
        ratio  = real'(k) / real'(ATAN_ENTRIES);
        // radians to table units, pi/4 maps to 2**OUTPUT_WIDTH
        scaled = $atan(ratio) * 4.0 / ATAN_PI * real'(2 ** OUTPUT_WIDTH);
        entry  = $rtoi(scaled + 0.5);
        // last entries stay below full scale, clamp anyway
        if (entry > 2 ** OUTPUT_WIDTH - 1) begin
            entry = 2 ** OUTPUT_WIDTH - 1;
        end
        table_v[k*OUTPUT_WIDTH +: OUTPUT_WIDTH] = OUTPUT_WIDTH'(entry);
    end
    return table_v;
endfunction

localparam logic [ATAN_ENTRIES*OUTPUT_WIDTH-1:0] ATAN_TABLE = build_atan_table();

// value returned for a ratio of all ones, i.e. pi/4
localparam logic [OUTPUT_WIDTH-1:0] ATAN_MAX = '1;

`endif
